/* design/fb_consts.svh */
// raster timing, framebuffer geometry and colour constants
// include wherever a module needs sizes or timing values

`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

`define FB_CORDW  16            // signed screen coordinate width

// horizontal timing in pixels
`define H_RES     640           // active width
`define H_FP      16            // front porch
`define H_SYNC    96            // sync pulse
`define H_BP      48            // back porch

// vertical timing in lines
`define V_RES     480
`define V_FP      10
`define V_SYNC    2
`define V_BP      33

`define FB_WIDTH  160           // framebuffer size in pixels
`define FB_HEIGHT 120
`define FB_PIXELS (`FB_WIDTH * `FB_HEIGHT)   // 19200 entries
`define FB_ADDRW  15            // enough for FB_PIXELS
`define FB_DATAW  1             // bits per pixel, mono

`define CHANW     4             // bits per colour channel
`define BG_COLR   12'h137       // colour around the framebuffer area
`define FB_LAT    2             // read lead: decision reg + bram reg

`endif

/* design/fb_pkg.sv */
// shared types for the framebuffer display pipeline
// referenced by scoped name from each RTL file

`include "fb_consts.svh"

package fb_pkg;

    // screen coordinate, negative values fall in blanking
    typedef logic signed [`FB_CORDW-1:0] coord_t;

    // one colour channel
    typedef logic [`CHANW-1:0] chan_t;

    // packed red, green, blue
    typedef logic [3*`CHANW-1:0] colr_t;

    // framebuffer word address
    typedef logic [`FB_ADDRW-1:0] fb_addr_t;

    // stored pixel value
    typedef logic [`FB_DATAW-1:0] pix_t;

endpackage

/* design/display_timing.sv */
// raster timing for a 640x480 display with signed coordinates
// blanking sits at negative sx/sy, active area starts at (0,0)

`include "fb_consts.svh"

module display_timing (
    input  logic           clk_pix,
    input  logic           rst,
    output fb_pkg::coord_t sx,      // horizontal position
    output fb_pkg::coord_t sy,      // vertical position
    output logic           hsync,   // active low
    output logic           vsync,   // active low
    output logic           de,      // active video
    output logic           frame    // one cycle at frame start
);

    // horizontal landmarks, line starts with front porch
    localparam fb_pkg::coord_t H_STA  = 0 - `H_FP - `H_SYNC - `H_BP;  // -160
    localparam fb_pkg::coord_t HS_STA = H_STA + `H_FP;                // sync begins
    localparam fb_pkg::coord_t HS_END = HS_STA + `H_SYNC;             // sync ends
    localparam fb_pkg::coord_t H_END  = `H_RES - 1;                   // last active pixel

    // vertical landmarks, same layout in lines
    localparam fb_pkg::coord_t V_STA  = 0 - `V_FP - `V_SYNC - `V_BP;  // -45
    localparam fb_pkg::coord_t VS_STA = V_STA + `V_FP;
    localparam fb_pkg::coord_t VS_END = VS_STA + `V_SYNC;
    localparam fb_pkg::coord_t V_END  = `V_RES - 1;

    localparam fb_pkg::coord_t COORD_ONE = 1;

    logic line_end;     // last pixel of a line
    logic frame_end;    // last line of a frame

    always_comb begin
        line_end  = (sx == H_END);
        frame_end = (sy == V_END);
    end

    // syncs and enable straight from the counters
    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);
        vsync = ~(sy >= VS_STA && sy < VS_END);
        de    = ~sx[`FB_CORDW-1] & ~sy[`FB_CORDW-1];   // both coords non-negative
        frame = (sx == H_STA) && (sy == V_STA);
    end

    // pixel and line counters
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= H_STA;    // restart in blanking at frame start
            sy <= V_STA;
        end else if (line_end) begin
            sx <= H_STA;
            if (frame_end) begin
                sy <= V_STA;    // wrap to next frame
            end else begin
                sy <= sy + COORD_ONE;
            end
        end else begin
            sx <= sx + COORD_ONE;
        end
    end

endmodule

/* design/fb_bram.sv */
// simple dual-port block RAM for framebuffer pixels, single clock
// registered read, one cycle from addr_read to data_out

`include "fb_consts.svh"

module fb_bram (
    input  logic             clk_pix,
    input  logic             we,           // write strobe
    input  fb_pkg::fb_addr_t addr_write,
    input  fb_pkg::pix_t     data_in,
    input  fb_pkg::fb_addr_t addr_read,
    output fb_pkg::pix_t     data_out      // valid a cycle after addr_read
);

    // one entry per framebuffer pixel, raster order
    fb_pkg::pix_t mem [`FB_PIXELS];

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, a same-address write returns the old word
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

/* design/fb_scan_ctrl.sv */
// framebuffer read control: address generation ahead of the raster
// also flags which screen pixels show framebuffer data

`include "fb_consts.svh"

module fb_scan_ctrl (
    input  logic             clk_pix,
    input  logic             rst,
    input  fb_pkg::coord_t   sx,
    input  fb_pkg::coord_t   sy,
    input  logic             frame,        // restart address
    output fb_pkg::fb_addr_t read_addr,    // to bram read port
    output logic             paint_area    // pixel lies in framebuffer
);

    // read window, shifted left by the pipeline lead
    localparam fb_pkg::coord_t RD_X_STA = 0 - `FB_LAT;                 // -2
    localparam fb_pkg::coord_t RD_X_END = `FB_WIDTH - `FB_LAT - 1;     // 157

    // paint window on screen
    localparam fb_pkg::coord_t FB_X_END = `FB_WIDTH - 1;   // 159
    localparam fb_pkg::coord_t FB_Y_END = `FB_HEIGHT - 1;  // 119

    localparam fb_pkg::fb_addr_t ADDR_ONE = 1;

    logic fb_rows;      // sy within framebuffer height
    logic read_now;     // unregistered read decision
    logic read_fb;      // registered decision

    always_comb begin
        fb_rows  = ~sy[`FB_CORDW-1] && (sy <= FB_Y_END);
        read_now = fb_rows && (sx >= RD_X_STA) && (sx <= RD_X_END);
    end

    // decision register, first stage of the lead
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            read_fb <= 1'b0;
        end else begin
            read_fb <= read_now;
        end
    end

    // address walks 160x120 in raster order, once per frame
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            read_addr <= '0;
        end else if (frame) begin
            read_addr <= '0;                      // back to top-left
        end else if (read_fb) begin
            read_addr <= read_addr + ADDR_ONE;    // next pixel
        end
    end

    // bram data lands on the pixel it belongs to
    always_comb begin
        paint_area = fb_rows && ~sx[`FB_CORDW-1] && (sx <= FB_X_END);
    end

endmodule

/* design/colour_out.sv */
// colour selection and registered output stage
// syncs, enable and colour leave on the same clock edge

`include "fb_consts.svh"

module colour_out (
    input  logic          clk_pix,
    input  logic          rst,
    input  fb_pkg::pix_t  pix,          // framebuffer pixel
    input  logic          paint_area,
    input  logic          hsync,
    input  logic          vsync,
    input  logic          de,
    output logic          dvi_hsync,
    output logic          dvi_vsync,
    output logic          dvi_de,
    output fb_pkg::chan_t dvi_r,
    output fb_pkg::chan_t dvi_g,
    output fb_pkg::chan_t dvi_b
);

    localparam fb_pkg::colr_t BG = `BG_COLR;

    fb_pkg::colr_t paint_colr;     // framebuffer or background
    fb_pkg::colr_t disp_colr;      // black in blanking

    always_comb begin
        // mono pixel spread over all channel bits
        paint_colr = paint_area ? {(3*`CHANW){pix[0]}} : BG;
        disp_colr  = de ? paint_colr : '0;
    end

    // output register stage
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            dvi_hsync <= 1'b1;  // syncs idle high
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            {dvi_r, dvi_g, dvi_b} <= '0;
        end else begin
            dvi_hsync <= hsync;
            dvi_vsync <= vsync;
            dvi_de    <= de;
            {dvi_r, dvi_g, dvi_b} <= disp_colr;
        end
    end

endmodule

/* design/fb_display_top.sv */
// mono framebuffer display: timing, read control, bram, output stage
// image is loaded through the fb_we write port

module fb_display_top (
    input  logic             clk_pix,
    input  logic             rst,
    input  logic             fb_we,        // framebuffer write strobe
    input  fb_pkg::fb_addr_t fb_waddr,
    input  fb_pkg::pix_t     fb_wdata,
    output logic             dvi_hsync,
    output logic             dvi_vsync,
    output logic             dvi_de,
    output fb_pkg::chan_t    dvi_r,
    output fb_pkg::chan_t    dvi_g,
    output fb_pkg::chan_t    dvi_b
);

    fb_pkg::coord_t   sx, sy;               // raster position
    logic             hsync, vsync, de;
    logic             frame;                // frame start strobe
    fb_pkg::fb_addr_t read_addr;
    logic             paint_area;
    fb_pkg::pix_t     pix;                  // bram read data

    display_timing timing_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    fb_scan_ctrl scan_inst (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .sx         (sx),
        .sy         (sy),
        .frame      (frame),
        .read_addr  (read_addr),
        .paint_area (paint_area)
    );

    fb_bram bram_inst (
        .clk_pix    (clk_pix),
        .we         (fb_we),
        .addr_write (fb_waddr),
        .data_in    (fb_wdata),
        .addr_read  (read_addr),
        .data_out   (pix)
    );

    colour_out out_inst (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .pix        (pix),
        .paint_area (paint_area),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .dvi_hsync  (dvi_hsync),
        .dvi_vsync  (dvi_vsync),
        .dvi_de     (dvi_de),
        .dvi_r      (dvi_r),
        .dvi_g      (dvi_g),
        .dvi_b      (dvi_b)
    );

endmodule

/* sim/fb_display_props.sv */
// concurrent checks on the display outputs and the internal frame strobe
// attached to fb_display_top with bind at the end of this file

`include "fb_consts.svh"

module fb_display_props (
    input logic          clk_pix,
    input logic          rst,
    input logic          dvi_de,
    input logic          dvi_hsync,
    input logic          frame,
    input fb_pkg::chan_t dvi_r,
    input fb_pkg::chan_t dvi_g,
    input fb_pkg::chan_t dvi_b
);

    int hs_low;     // low cycles in the current hsync pulse

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hs_low <= 0;
        end else if (!dvi_hsync) begin
            hs_low <= hs_low + 1;
        end else begin
            hs_low <= 0;    // idle high, restart count
        end
    end

    // black outside active video
    blank_black: assert property (@(posedge clk_pix) disable iff (rst)
        !dvi_de |-> ({dvi_r, dvi_g, dvi_b} == 12'h000))
        else $error("colour not zero while dvi_de is low");

    // hsync pulse width, checked when the pulse ends
    hsync_width: assert property (@(posedge clk_pix) disable iff (rst)
        $rose(dvi_hsync) |-> (hs_low == `H_SYNC))
        else $error("dvi_hsync low pulse lasted %0d cycles", hs_low);

    frame_single: assert property (@(posedge clk_pix) disable iff (rst)
        frame |=> !frame)
        else $error("frame strobe high for two cycles");

endmodule

bind fb_display_top fb_display_props props_inst (
    .clk_pix   (clk_pix),
    .rst       (rst),
    .dvi_de    (dvi_de),
    .dvi_hsync (dvi_hsync),
    .frame     (frame),
    .dvi_r     (dvi_r),
    .dvi_g     (dvi_g),
    .dvi_b     (dvi_b)
);

/* sim/fb_display_tb.sv */
// testbench for fb_display_top: loads a random image, then checks raster and colours
// stimulus and probe colours come from sim/fb_display_stim.txt

`include "fb_consts.svh"

module fb_display_tb;

    localparam int H_TOTAL = `H_RES + `H_FP + `H_SYNC + `H_BP;   // 800
    localparam int NPIX    = `FB_WIDTH * `FB_HEIGHT;
    localparam int SCR     = `H_RES * `V_RES;
    localparam int FRAME_CYC = H_TOTAL * (`V_RES + `V_FP + `V_SYNC + `V_BP);

    logic             clk_pix = 1'b0;
    logic             rst;
    logic             fb_we;
    fb_pkg::fb_addr_t fb_waddr;
    fb_pkg::pix_t     fb_wdata;
    logic             dvi_hsync, dvi_vsync, dvi_de;
    fb_pkg::chan_t    dvi_r, dvi_g, dvi_b;

    logic        model [NPIX];      // expected framebuffer contents
    logic [11:0] cap [SCR];         // last captured active picture
    int          seed, tests, failed;
    bit          timed_out;
    int          probe_x[$], probe_y[$];
    logic [11:0] probe_c[$];

    // output monitor state
    int   row, col, runs, hs_cnt, hs_low, vs_low;
    int   frames_done, geom_err, blank_err;
    bit   hs_seen, vs_seen;
    logic prev_de, prev_hs, prev_vs;

    fb_display_top UUT (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .fb_we     (fb_we),
        .fb_waddr  (fb_waddr),
        .fb_wdata  (fb_wdata),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

    always #50 clk_pix = ~clk_pix;

    // colour rule: framebuffer pixel inside 160x120, background elsewhere
    function automatic logic [11:0] expected_colour(input int x, input int y);
        if (x < `FB_WIDTH && y < `FB_HEIGHT) begin
            return model[y * `FB_WIDTH + x] ? 12'hFFF : 12'h000;
        end
        return `BG_COLR;
    endfunction

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge clk_pix) begin
        if (rst) begin
            prev_de = 1'b0;
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            row = -1;
            col = 0;
            runs = 0;
            hs_cnt = 0;
            hs_low = 0;
            vs_low = 0;
            hs_seen = 1'b0;
            vs_seen = 1'b0;
        end else begin
            if (!dvi_de && {dvi_r, dvi_g, dvi_b} != 12'h000) begin
                blank_err++;
                $display("mismatch blanking expected 000 actual %h", {dvi_r, dvi_g, dvi_b});
            end
            hs_cnt++;
            if (prev_hs && !dvi_hsync) begin      // line boundary
                if (hs_seen && hs_cnt != H_TOTAL) begin
                    geom_err++;
                    $display("mismatch raster_geometry hsync_period expected %0d actual %0d",
                             H_TOTAL, hs_cnt);
                end
                hs_seen = 1'b1;
                hs_cnt = 0;
                hs_low = 0;
            end
            if (!dvi_hsync) hs_low++;
            if (!prev_hs && dvi_hsync && hs_seen && hs_low != `H_SYNC) begin
                geom_err++;
                $display("mismatch raster_geometry hsync_width expected %0d actual %0d",
                         `H_SYNC, hs_low);
            end
            if (prev_vs && !dvi_vsync) begin      // new frame, y restarts
                if (vs_seen && runs != `V_RES) begin
                    geom_err++;
                    $display("mismatch raster_geometry de_runs expected %0d actual %0d",
                             `V_RES, runs);
                end
                vs_seen = 1'b1;
                runs = 0;
                row = -1;
                vs_low = 0;
            end
            if (!dvi_vsync) vs_low++;
            if (!prev_vs && dvi_vsync && vs_low != `V_SYNC * H_TOTAL) begin
                geom_err++;
                $display("mismatch raster_geometry vsync_width expected %0d actual %0d",
                         `V_SYNC * H_TOTAL, vs_low);
            end
            if (dvi_de && !prev_de) begin
                row++;
                col = 0;
                runs++;
            end
            if (dvi_de) begin
                if (row >= 0 && row < `V_RES && col < `H_RES) cap[row * `H_RES + col] =
                    {dvi_r, dvi_g, dvi_b};
                col++;
            end
            if (!dvi_de && prev_de) begin          // end of a de run
                if (col != `H_RES) begin
                    geom_err++;
                    $display("mismatch raster_geometry de_length expected %0d actual %0d",
                             `H_RES, col);
                end
                if (row == `V_RES - 1) frames_done++;
            end
            prev_de = dvi_de;
            prev_hs = dvi_hsync;
            prev_vs = dvi_vsync;
        end
    end

    task automatic report(input string name, input int errs);
        tests++;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail, %0d errors", name, errs);
        end
    endtask

    task automatic wait_frame(output bit ok);
        int start;
        int n;
        start = frames_done;
        n = 0;
        while (frames_done == start && n < 2 * FRAME_CYC) begin
            @(negedge clk_pix);
            n++;
        end
        ok = (frames_done != start);
        if (!ok) begin
            $display("timeout: no complete frame seen within %0d cycles", 2 * FRAME_CYC);
            timed_out = 1'b1;
        end
    endtask

    // release edge value, then the first counter-driven value
    task automatic check_reset();
        int errs;
        int i;
        errs = 0;
        for (i = 0; i < 2; i++) begin
            if (dvi_de !== 1'b0) begin
                errs++;
                $display("mismatch reset_state de expected 0 actual %b", dvi_de);
            end
            if ({dvi_r, dvi_g, dvi_b} !== 12'h000) begin
                errs++;
                $display("mismatch reset_state colour expected 000 actual %h",
                         {dvi_r, dvi_g, dvi_b});
            end
            if (dvi_hsync !== 1'b1 || dvi_vsync !== 1'b1) begin
                errs++;
                $display("mismatch reset_state syncs expected 11 actual %b%b",
                         dvi_hsync, dvi_vsync);
            end
            @(negedge clk_pix);
        end
        report("reset_state", errs);
    endtask

    task automatic load_image();
        int i;
        int r;
        for (i = 0; i < NPIX; i++) begin
            r = $random(seed);
            model[i] = r[0];
            fb_we = 1'b1;
            fb_waddr = fb_pkg::fb_addr_t'(i);
            fb_wdata = r[0];
            @(negedge clk_pix);
        end
        fb_we = 1'b0;
    endtask

    task automatic check_full_frame();
        int x;
        int y;
        int errs;
        logic [11:0] e;
        errs = 0;
        for (y = 0; y < `V_RES; y++) begin
            for (x = 0; x < `H_RES; x++) begin
                e = expected_colour(x, y);
                if (cap[y * `H_RES + x] !== e) begin
                    errs++;
                    if (errs <= 10) begin
                        $display("mismatch full_frame x=%0d y=%0d expected %h actual %h",
                                 x, y, e, cap[y * `H_RES + x]);
                    end
                end
            end
        end
        report("full_frame", errs);
    endtask

    // framebuffer border, where the read lead has to line up
    task automatic check_border_pixels();
        int ex[5] = '{0, 1, 158, 159, 160};
        int ey[4] = '{0, 118, 119, 120};
        int i;
        int j;
        int errs;
        logic [11:0] e;
        errs = 0;
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 4; j++) begin
                e = expected_colour(ex[i], ey[j]);
                if (cap[ey[j] * `H_RES + ex[i]] !== e) begin
                    errs++;
                    $display("mismatch border_pixels x=%0d y=%0d expected %h actual %h",
                             ex[i], ey[j], e, cap[ey[j] * `H_RES + ex[i]]);
                end
            end
        end
        report("border_pixels", errs);
    endtask

    task automatic apply_stim();
        int fd;
        int code;
        int a;
        int b;
        int x;
        int y;
        logic [11:0] c;
        logic [7:0] kind;
        reg [8*200-1:0] line;
        fd = $fopen("sim/fb_display_stim.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open sim/fb_display_stim.txt");
            timed_out = 1'b1;
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1) begin
                if (kind == "#") begin
                    code = $fgets(line, fd);     // comment line
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%d %d", a, b);
                    model[a] = b[0];
                    fb_we = 1'b1;
                    fb_waddr = fb_pkg::fb_addr_t'(a);
                    fb_wdata = b[0];
                    @(negedge clk_pix);
                    fb_we = 1'b0;
                end else if (kind == "P") begin
                    code = $fscanf(fd, "%d %d %h", x, y, c);
                    probe_x.push_back(x);
                    probe_y.push_back(y);
                    probe_c.push_back(c);
                end else begin
                    $display("error: unknown record type %c in stim file", kind);
                    timed_out = 1'b1;
                end
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_probes();
        int i;
        int errs;
        logic [11:0] got;
        errs = 0;
        if (probe_x.size() == 0) begin
            errs++;
            $display("error: stim file holds no probe records");
        end
        for (i = 0; i < probe_x.size(); i++) begin
            got = cap[probe_y[i] * `H_RES + probe_x[i]];
            if (got !== probe_c[i]) begin
                errs++;
                $display("mismatch stim_probes x=%0d y=%0d expected %h actual %h",
                         probe_x[i], probe_y[i], probe_c[i], got);
            end
        end
        report("stim_probes", errs);
    endtask

    initial begin
        bit ok;
        rst = 1'b1;
        fb_we = 1'b0;
        fb_waddr = '0;
        fb_wdata = '0;
        seed = 34518;
        tests = 0;
        failed = 0;
        timed_out = 1'b0;
        frames_done = 0;
        geom_err = 0;
        blank_err = 0;
        ok = 1'b0;
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        rst = 1'b0;
        check_reset();
        load_image();                    // done well before the first active line
        wait_frame(ok);
        if (ok) begin
            check_full_frame();
            apply_stim();                // writes land in vertical blanking
            wait_frame(ok);
        end
        if (ok) begin
            check_probes();
            check_border_pixels();       // border of the frame after the stim writes
            if (!hs_seen) begin
                geom_err++;
                $display("error: no falling edge of dvi_hsync seen on the outputs");
            end
            report("raster_geometry", geom_err);
            report("blanking", blank_err);
        end
        if (timed_out) failed++;
        $display("tests run %0d, failed %0d", tests, failed);
        if (failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* fb_display_top.f */
+incdir+design
design/fb_pkg.sv
design/display_timing.sv
design/fb_bram.sv
design/fb_scan_ctrl.sv
design/colour_out.sv
design/fb_display_top.sv
sim/fb_display_props.sv
sim/fb_display_tb.sv

/* Makefile */
# Verilator build and run for the framebuffer display testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= fb_display_tb
FILELIST  ?= fb_display_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the simulation output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/fb_display_stim.txt */
# W <address dec> <bit>        framebuffer write, applied in vertical blanking
# P <x dec> <y dec> <rgb hex>  expected colour of that pixel in the next frame
W 0 1
W 159 0
W 160 1
W 19040 0
W 19199 1
W 8080 1
W 8081 0
W 12345 1
W 4799 0
W 4800 1
W 100 0
W 100 1
# corners and rows of the framebuffer
P 0 0 fff
P 159 0 000
P 0 1 fff
P 0 119 000
P 159 119 fff
P 80 50 fff
P 81 50 000
P 25 77 fff
P 159 29 000
P 0 30 fff
P 100 0 fff
# background around the framebuffer
P 160 0 137
P 160 119 137
P 0 120 137
P 159 120 137
P 300 200 137
P 639 0 137
P 0 479 137
P 639 479 137
